/* source/daq_format_pkg.sv */
package daq_format_pkg;

    // ============================================================
    // sample and frame field widths
    // ============================================================
    localparam int SAMPLE_WIDTH         = 16;
    localparam int TIMESTAMP_WIDTH      = 48;
    localparam int TRIGGER_INFO_WIDTH   = 8;
    localparam int TRIGGER_CONFIG_WIDTH = 16;

    // the hit mask sits in the upper bits of the trigger info field
    localparam int HIT_MASK_WIDTH = 6;
    localparam int HIT_MASK_LSB   = TRIGGER_INFO_WIDTH - HIT_MASK_WIDTH;

    // ============================================================
    // frame word layout, config field at the bottom
    // ============================================================
    localparam int CONFIG_LSB       = 0;
    localparam int TIMESTAMP_LSB    = CONFIG_LSB + TRIGGER_CONFIG_WIDTH;
    localparam int TRIGGER_INFO_LSB = TIMESTAMP_LSB + TIMESTAMP_WIDTH;
    localparam int SAMPLES_LSB      = TRIGGER_INFO_LSB + TRIGGER_INFO_WIDTH;

    // width of all samples of one beat
    function automatic int adc_width(int samples_per_beat);
        return SAMPLE_WIDTH * samples_per_beat;
    endfunction

    // width of the whole frame word
    function automatic int frame_width(int samples_per_beat);
        return SAMPLES_LSB + adc_width(samples_per_beat);
    endfunction

endpackage

/* source/trigger_pkg.sv */
package trigger_pkg;

    localparam int TRIGGER_TYPE_WIDTH = 2;
    localparam int REG_ADDR_WIDTH     = 4;
    localparam int AXIL_DATA_WIDTH    = 32;
    localparam int THRESHOLD_WIDTH    = 16;

    // codes other than these two behave as a hardware trigger
    typedef enum logic [TRIGGER_TYPE_WIDTH-1:0] {
        HARDWARE_TRG = 2'd0,
        EXTERNAL_TRG = 2'd1
    } trigger_type_e;

    // ============================================================
    // register map
    // ============================================================
    typedef enum logic [REG_ADDR_WIDTH-1:0] {
        REG_CTRL        = 4'h0,
        REG_TRIG_TYPE   = 4'h4,
        REG_THRESHOLD   = 4'h8,
        REG_FRAME_COUNT = 4'hC
    } reg_addr_e;

    localparam logic          STOP_RESET         = 1'b0;
    localparam trigger_type_e TRIGGER_TYPE_RESET = HARDWARE_TRG;
    localparam logic signed [THRESHOLD_WIDTH-1:0] THRESHOLD_RESET = 16'sd2048;

endpackage

/* source/axil_trigger_regs.sv */
module axil_trigger_regs
    import trigger_pkg::*;
(
    input  logic                         ACLK,
    input  logic                         ARESET,
    input  logic [REG_ADDR_WIDTH-1:0]    s_axil_awaddr,
    input  logic                         s_axil_awvalid,
    output logic                         s_axil_awready,
    input  logic [AXIL_DATA_WIDTH-1:0]   s_axil_wdata,
    input  logic [AXIL_DATA_WIDTH/8-1:0] s_axil_wstrb,
    input  logic                         s_axil_wvalid,
    output logic                         s_axil_wready,
    output logic [1:0]                   s_axil_bresp,
    output logic                         s_axil_bvalid,
    input  logic                         s_axil_bready,
    input  logic [REG_ADDR_WIDTH-1:0]    s_axil_araddr,
    input  logic                         s_axil_arvalid,
    output logic                         s_axil_arready,
    output logic [AXIL_DATA_WIDTH-1:0]   s_axil_rdata,
    output logic [1:0]                   s_axil_rresp,
    output logic                         s_axil_rvalid,
    input  logic                         s_axil_rready,
    input  logic                         frame_valid,
    output logic                         stop,
    output trigger_type_e                trigger_type,
    output logic signed [THRESHOLD_WIDTH-1:0] threshold,
    output logic                         set_config
);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic                       write_fire;
    logic                       read_fire;
    logic [AXIL_DATA_WIDTH-1:0] frame_count;

    // address and data are taken straight from the bus in the ready cycle
    assign write_fire = s_axil_awready && s_axil_awvalid && s_axil_wready && s_axil_wvalid;
    assign read_fire  = s_axil_arready && s_axil_arvalid;

    assign s_axil_bresp = RESP_OKAY;
    assign s_axil_rresp = RESP_OKAY;

    // ============================================================
    // write channel
    // ============================================================
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            s_axil_awready <= 1'b0;
            s_axil_wready  <= 1'b0;
            s_axil_bvalid  <= 1'b0;
        end else begin
            if (!s_axil_awready && !s_axil_bvalid && s_axil_awvalid && s_axil_wvalid) begin
                s_axil_awready <= 1'b1;
                s_axil_wready  <= 1'b1;
            end else begin
                s_axil_awready <= 1'b0;
                s_axil_wready  <= 1'b0;
            end
            if (write_fire) begin
                s_axil_bvalid <= 1'b1;
            end else if (s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end
        end
    end

    // set_config lines up with the first cycle the new value is visible
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            stop         <= STOP_RESET;
            trigger_type <= TRIGGER_TYPE_RESET;
            threshold    <= THRESHOLD_RESET;
            set_config   <= 1'b0;
        end else begin
            set_config <= 1'b0;
            if (write_fire) begin
                case (reg_addr_e'(s_axil_awaddr))
                    REG_CTRL: begin
                        if (s_axil_wstrb[0]) begin
                            stop <= s_axil_wdata[0];
                        end
                    end
                    REG_TRIG_TYPE: begin
                        if (s_axil_wstrb[0]) begin
                            trigger_type <= trigger_type_e'(s_axil_wdata[TRIGGER_TYPE_WIDTH-1:0]);
                        end
                        set_config <= 1'b1;
                    end
                    REG_THRESHOLD: begin
                        if (s_axil_wstrb[0]) begin
                            threshold[7:0] <= s_axil_wdata[7:0];
                        end
                        if (s_axil_wstrb[1]) begin
                            threshold[15:8] <= s_axil_wdata[15:8];
                        end
                        set_config <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // ============================================================
    // read channel
    // ============================================================
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            s_axil_arready <= 1'b0;
            s_axil_rvalid  <= 1'b0;
        end else begin
            s_axil_arready <= !s_axil_arready && !s_axil_rvalid && s_axil_arvalid;
            if (read_fire) begin
                s_axil_rvalid <= 1'b1;
            end else if (s_axil_rready) begin
                s_axil_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (read_fire) begin
            case (reg_addr_e'(s_axil_araddr))
                REG_CTRL:        s_axil_rdata <= {{(AXIL_DATA_WIDTH-1){1'b0}}, stop};
                REG_TRIG_TYPE:   s_axil_rdata <= AXIL_DATA_WIDTH'(trigger_type);
                REG_THRESHOLD:   s_axil_rdata <= AXIL_DATA_WIDTH'(threshold);
                REG_FRAME_COUNT: s_axil_rdata <= frame_count;
                default:         s_axil_rdata <= '0;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            frame_count <= '0;
        end else if (frame_valid) begin
            frame_count <= frame_count + 1'b1;
        end
    end

endmodule

/* source/threshold_trigger.sv */
module threshold_trigger
    import daq_format_pkg::*, trigger_pkg::*;
#(
    parameter  int SAMPLES_PER_BEAT = 4,
    localparam int ADC_WIDTH        = adc_width(SAMPLES_PER_BEAT),
    localparam int FRAME_WIDTH      = frame_width(SAMPLES_PER_BEAT)
) (
    input  logic                              ACLK,
    input  logic                              ARESET,
    input  logic                              adc_tvalid,
    input  logic [ADC_WIDTH-1:0]              adc_tdata,
    input  logic signed [THRESHOLD_WIDTH-1:0] threshold,
    output logic                              hw_tvalid,
    output logic [FRAME_WIDTH-1:0]            frame_tdata
);

    logic [TIMESTAMP_WIDTH-1:0] timestamp;
    logic [HIT_MASK_WIDTH-1:0]  hit_mask;
    logic [FRAME_WIDTH-1:0]     frame_next;

    // ============================================================
    // free running timestamp
    // ============================================================
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            timestamp <= '0;
        end else begin
            timestamp <= timestamp + 1'b1;
        end
    end

    // ============================================================
    // per sample comparison
    // ============================================================
    // mask bits above SAMPLES_PER_BEAT stay zero
    always_comb begin
        hit_mask = '0;
        for (int i = 0; i < SAMPLES_PER_BEAT; i++) begin
            hit_mask[i] = $signed(adc_tdata[i*SAMPLE_WIDTH +: SAMPLE_WIDTH]) > threshold;
        end
    end

    // type bits are left zero, the selector fills them in
    always_comb begin
        frame_next = '0;
        frame_next[SAMPLES_LSB +: ADC_WIDTH] = adc_tdata;
        frame_next[TRIGGER_INFO_LSB + HIT_MASK_LSB +: HIT_MASK_WIDTH] = hit_mask;
        frame_next[TIMESTAMP_LSB +: TIMESTAMP_WIDTH] = timestamp;
        frame_next[CONFIG_LSB +: TRIGGER_CONFIG_WIDTH] = threshold;
    end

    // the frame register loads every cycle so data always trails the input by one
    always_ff @(posedge ACLK) begin
        frame_tdata <= frame_next;
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            hw_tvalid <= 1'b0;
        end else begin
            hw_tvalid <= adc_tvalid && (|hit_mask);
        end
    end

endmodule

/* source/trigger_selector.sv */
module trigger_selector
    import daq_format_pkg::*, trigger_pkg::*;
#(
    parameter  int SAMPLES_PER_BEAT = 4,
    localparam int ADC_WIDTH        = adc_width(SAMPLES_PER_BEAT),
    localparam int FRAME_WIDTH      = frame_width(SAMPLES_PER_BEAT)
) (
    input  logic                   ACLK,
    input  logic                   ARESET,
    input  logic                   set_config,
    input  logic                   stop,
    input  trigger_type_e          trigger_type,
    input  logic                   ext_trigger,
    input  logic                   frame_tvalid,
    input  logic [FRAME_WIDTH-1:0] frame_tdata,
    input  logic [ADC_WIDTH-1:0]   hg_tdata_in,
    output logic                   m_axis_tvalid,
    output logic [FRAME_WIDTH-1:0] m_axis_tdata,
    output logic [ADC_WIDTH-1:0]   hg_tdata
);

    trigger_type_e          type_q;
    logic                   ext_meta;
    logic                   ext_sync;
    logic                   tvalid_d;
    logic [FRAME_WIDTH-1:0] frame_stamped;
    logic [FRAME_WIDTH-1:0] tdata_d;
    logic [ADC_WIDTH-1:0]   hg_d;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            type_q <= TRIGGER_TYPE_RESET;
        end else if (set_config) begin
            type_q <= trigger_type;
        end
    end

    // two flop synchronizer for the external pin
    always_ff @(posedge ACLK) begin
        ext_meta <= ext_trigger;
        ext_sync <= ext_meta;
    end

    always_comb begin
        frame_stamped = frame_tdata;
        frame_stamped[TRIGGER_INFO_LSB +: TRIGGER_TYPE_WIDTH] = type_q;
    end

    // ============================================================
    // two aligned output stages
    // ============================================================
    always_ff @(posedge ACLK) begin
        tdata_d      <= frame_stamped;
        m_axis_tdata <= tdata_d;
        hg_d         <= hg_tdata_in;
        hg_tdata     <= hg_d;
    end

    always_ff @(posedge ACLK) begin
        if (ARESET || set_config || stop) begin
            tvalid_d <= 1'b0;
        end else begin
            case (type_q)
                EXTERNAL_TRG: tvalid_d <= ext_sync;
                default:      tvalid_d <= frame_tvalid;
            endcase
        end
    end

    // stop only acts on the first stage, so one valid may still drain
    always_ff @(posedge ACLK) begin
        if (ARESET || set_config) begin
            m_axis_tvalid <= 1'b0;
        end else begin
            m_axis_tvalid <= tvalid_d;
        end
    end

endmodule

/* source/trigger_frontend_top.sv */
module trigger_frontend_top
    import daq_format_pkg::*, trigger_pkg::*;
#(
    parameter  int SAMPLES_PER_BEAT = 4,
    localparam int ADC_WIDTH        = adc_width(SAMPLES_PER_BEAT),
    localparam int FRAME_WIDTH      = frame_width(SAMPLES_PER_BEAT)
) (
    input  logic                         ACLK,
    input  logic                         ARESET,
    input  logic [REG_ADDR_WIDTH-1:0]    s_axil_awaddr,
    input  logic                         s_axil_awvalid,
    output logic                         s_axil_awready,
    input  logic [AXIL_DATA_WIDTH-1:0]   s_axil_wdata,
    input  logic [AXIL_DATA_WIDTH/8-1:0] s_axil_wstrb,
    input  logic                         s_axil_wvalid,
    output logic                         s_axil_wready,
    output logic [1:0]                   s_axil_bresp,
    output logic                         s_axil_bvalid,
    input  logic                         s_axil_bready,
    input  logic [REG_ADDR_WIDTH-1:0]    s_axil_araddr,
    input  logic                         s_axil_arvalid,
    output logic                         s_axil_arready,
    output logic [AXIL_DATA_WIDTH-1:0]   s_axil_rdata,
    output logic [1:0]                   s_axil_rresp,
    output logic                         s_axil_rvalid,
    input  logic                         s_axil_rready,
    input  logic                         adc_tvalid,
    input  logic [ADC_WIDTH-1:0]         adc_tdata,
    input  logic [ADC_WIDTH-1:0]         hg_tdata_in,
    input  logic                         ext_trigger,
    output logic                         m_axis_tvalid,
    output logic [FRAME_WIDTH-1:0]       m_axis_tdata,
    output logic [ADC_WIDTH-1:0]         hg_tdata
);

    logic                              stop;
    trigger_type_e                     trigger_type;
    logic signed [THRESHOLD_WIDTH-1:0] threshold;
    logic                              set_config;
    logic                              hw_tvalid;
    logic [FRAME_WIDTH-1:0]            frame_tdata;

    // the frame counter watches the stream output
    axil_trigger_regs u_regs (
        .frame_valid  (m_axis_tvalid),
        .*
    );

    threshold_trigger #(
        .SAMPLES_PER_BEAT(SAMPLES_PER_BEAT)
    ) u_hw_trigger (
        .ACLK        (ACLK),
        .ARESET      (ARESET),
        .adc_tvalid  (adc_tvalid),
        .adc_tdata   (adc_tdata),
        .threshold   (threshold),
        .hw_tvalid   (hw_tvalid),
        .frame_tdata (frame_tdata)
    );

    trigger_selector #(
        .SAMPLES_PER_BEAT(SAMPLES_PER_BEAT)
    ) u_selector (
        .frame_tvalid (hw_tvalid),
        .*
    );

endmodule

/* verif/tb_trigger_frontend.sv */
module tb_trigger_frontend
    import daq_format_pkg::*, trigger_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int         SPB            = 4;
    localparam int         ADC_W          = adc_width(SPB);
    localparam int         FRAME_W        = frame_width(SPB);
    localparam int         TIMEOUT_CYCLES = 20;
    localparam logic [1:0] OKAY           = 2'b00;

    logic                         ACLK;
    logic                         ARESET;
    logic [REG_ADDR_WIDTH-1:0]    s_axil_awaddr;
    logic                         s_axil_awvalid;
    logic                         s_axil_awready;
    logic [AXIL_DATA_WIDTH-1:0]   s_axil_wdata;
    logic [AXIL_DATA_WIDTH/8-1:0] s_axil_wstrb;
    logic                         s_axil_wvalid;
    logic                         s_axil_wready;
    logic [1:0]                   s_axil_bresp;
    logic                         s_axil_bvalid;
    logic                         s_axil_bready;
    logic [REG_ADDR_WIDTH-1:0]    s_axil_araddr;
    logic                         s_axil_arvalid;
    logic                         s_axil_arready;
    logic [AXIL_DATA_WIDTH-1:0]   s_axil_rdata;
    logic [1:0]                   s_axil_rresp;
    logic                         s_axil_rvalid;
    logic                         s_axil_rready;
    logic                         adc_tvalid;
    logic [ADC_W-1:0]             adc_tdata;
    logic [ADC_W-1:0]             hg_tdata_in;
    logic                         ext_trigger;
    logic                         m_axis_tvalid;
    logic [FRAME_W-1:0]           m_axis_tdata;
    logic [ADC_W-1:0]             hg_tdata;

    // reference model state
    integer                            seed;
    int                                errors;
    int                                cycle;
    int                                last_cycle;
    int                                seen_frames;
    logic                              stream_on;
    logic                              ext_request;
    logic                              ext_last;
    logic                              model_stop;
    trigger_type_e                     model_type;
    logic signed [THRESHOLD_WIDTH-1:0] model_threshold;
    logic [TIMESTAMP_WIDTH-1:0]        ts_model;
    logic [TIMESTAMP_WIDTH-1:0]        last_ts;
    logic [FRAME_W-1:0]                q_frame[$];
    logic                              q_valid[$];
    logic                              q_raw[$];
    logic [ADC_W-1:0]                  q_hg[$];
    logic                              check_on;
    logic                              data_on;
    logic                              hg_on;
    logic                              exp_valid;
    logic [FRAME_W-1:0]                exp_frame;
    logic [ADC_W-1:0]                  exp_hg;

    trigger_frontend_top #(
        .SAMPLES_PER_BEAT(SPB)
    ) dut (.*);

    always #20 ACLK = ~ACLK;

    function automatic void value_error(input string name, input logic [FRAME_W-1:0] got,
                                        input logic [FRAME_W-1:0] expected);
        errors++;
        $display("ERROR %0t %s got %h expected %h", $time, name, got, expected);
    endfunction

    function automatic void report_failure(input string what);
        errors++;
        $display("ERROR %0t %s", $time, what);
    endfunction

    // ============================================================
    // outputs are compared with the model at the rising edge
    // ============================================================
    assert property (@(posedge ACLK) !check_on || (m_axis_tvalid == exp_valid))
        else value_error("m_axis_tvalid", FRAME_W'($sampled(m_axis_tvalid)),
                         FRAME_W'($sampled(exp_valid)));
    assert property (@(posedge ACLK) !data_on || (m_axis_tdata == exp_frame))
        else value_error("m_axis_tdata", $sampled(m_axis_tdata), $sampled(exp_frame));
    assert property (@(posedge ACLK) !hg_on || (hg_tdata == exp_hg))
        else value_error("hg_tdata", FRAME_W'($sampled(hg_tdata)), FRAME_W'($sampled(exp_hg)));

    // each call drives one clock of stimulus and the model follows every beat driven here
    task automatic tick();
        logic [HIT_MASK_WIDTH-1:0]  mask;
        logic [TIMESTAMP_WIDTH-1:0] ts_seen;
        logic                       raw;
        integer                     rnd;
        @(negedge ACLK);
        cycle++;
        check_on = 1'b1;
        if (m_axis_tvalid) begin
            ts_seen = m_axis_tdata[TIMESTAMP_LSB +: TIMESTAMP_WIDTH];
            if (seen_frames > 0) begin
                assert (ts_seen - last_ts == TIMESTAMP_WIDTH'(cycle - last_cycle))
                    else value_error("timestamp step", FRAME_W'(ts_seen - last_ts),
                                     FRAME_W'(cycle - last_cycle));
            end
            last_ts    = ts_seen;
            last_cycle = cycle;
            seen_frames++;
        end
        for (int i = 0; i < SPB; i++) begin
            rnd = $random(seed);
            adc_tdata[i*SAMPLE_WIDTH +: SAMPLE_WIDTH]   = rnd[15:0];
            hg_tdata_in[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = rnd[31:16];
        end
        rnd = $random(seed);
        adc_tvalid  = stream_on && (rnd[2:0] != 3'd0);
        ext_trigger = ext_request;
        ext_request = 1'b0;
        mask = '0;
        for (int i = 0; i < SPB; i++) begin
            mask[i] = $signed(adc_tdata[i*SAMPLE_WIDTH +: SAMPLE_WIDTH]) > model_threshold;
        end
        ts_model++;
        // an external pulse pairs with the beat one cycle after it
        if (model_type == EXTERNAL_TRG) begin
            raw = ext_last;
        end else begin
            raw = adc_tvalid && (|mask);
        end
        ext_last = ext_trigger;
        q_frame.push_back({adc_tdata, mask, model_type, ts_model, model_threshold});
        q_raw.push_back(raw);
        q_valid.push_back(raw && !model_stop);
        q_hg.push_back(hg_tdata_in);
        exp_valid = 1'b0;
        if (q_frame.size() > 3) begin
            exp_frame = q_frame.pop_front();
            exp_valid = q_valid.pop_front();
            void'(q_raw.pop_front());
            data_on = 1'b1;
        end
        if (q_hg.size() > 2) begin
            exp_hg = q_hg.pop_front();
            hg_on  = 1'b1;
        end
    endtask

    task automatic run_cycles(input int n);
        repeat (n) tick();
    endtask

    // the beat driven in the handshake cycle is the last one with the old setup
    task automatic apply_write(input logic [REG_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        int last;
        last = q_valid.size() - 1;
        case (reg_addr_e'(addr))
            REG_CTRL: begin
                model_stop    = data[0];
                q_valid[last] = q_raw[last] && !model_stop;
            end
            REG_TRIG_TYPE, REG_THRESHOLD: begin
                q_valid[last] = 1'b0;
                if (last > 0) begin
                    q_valid[last-1] = 1'b0;
                end
                if (reg_addr_e'(addr) == REG_TRIG_TYPE) begin
                    model_type = trigger_type_e'(data[TRIGGER_TYPE_WIDTH-1:0]);
                end else begin
                    model_threshold = data[THRESHOLD_WIDTH-1:0];
                end
            end
            default: ;
        endcase
    endtask

    // ============================================================
    // AXI4-Lite access
    // ============================================================
    task automatic axil_write(input logic [REG_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        int waited;
        tick();
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        waited = 0;
        tick();
        while (!(s_axil_awready && s_axil_wready) && waited < TIMEOUT_CYCLES) begin
            tick();
            waited++;
        end
        if (s_axil_awready && s_axil_wready) begin
            apply_write(addr, data);
        end else begin
            report_failure("write address and data were never accepted");
        end
        tick();
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        if (s_axil_awready || s_axil_wready) begin
            report_failure("write ready stayed high after the handshake cycle");
        end
        waited = 0;
        while (!s_axil_bvalid && waited < TIMEOUT_CYCLES) begin
            tick();
            waited++;
        end
        if (!s_axil_bvalid) begin
            report_failure("write response never arrived");
        end else begin
            assert (s_axil_bresp == OKAY)
                else value_error("s_axil_bresp", FRAME_W'(s_axil_bresp), FRAME_W'(OKAY));
        end
    endtask

    task automatic axil_read(input logic [REG_ADDR_WIDTH-1:0] addr, input logic [31:0] expected,
                             input string name);
        int waited;
        tick();
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        waited = 0;
        tick();
        while (!s_axil_arready && waited < TIMEOUT_CYCLES) begin
            tick();
            waited++;
        end
        if (!s_axil_arready) begin
            report_failure("read address was never accepted");
        end
        tick();
        s_axil_arvalid = 1'b0;
        waited = 0;
        while (!s_axil_rvalid && waited < TIMEOUT_CYCLES) begin
            tick();
            waited++;
        end
        if (!s_axil_rvalid) begin
            report_failure("read data never arrived");
        end else begin
            assert (s_axil_rdata == expected)
                else value_error(name, FRAME_W'(s_axil_rdata), FRAME_W'(expected));
            assert (s_axil_rresp == OKAY)
                else value_error("s_axil_rresp", FRAME_W'(s_axil_rresp), FRAME_W'(OKAY));
        end
    endtask

    task automatic finish_run();
        $display("frames seen %0d, errors %0d", seen_frames, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    initial begin
        ACLK           = 1'b0;
        ARESET         = 1'b1;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = 4'hF;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b1;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b1;
        adc_tvalid     = 1'b0;
        adc_tdata      = '0;
        hg_tdata_in    = '0;
        ext_trigger    = 1'b0;
        seed            = 32'h593a_ecaa;
        errors          = 0;
        cycle           = 0;
        last_cycle      = 0;
        seen_frames     = 0;
        stream_on       = 1'b0;
        ext_request     = 1'b0;
        ext_last        = 1'b0;
        model_stop      = STOP_RESET;
        model_type      = TRIGGER_TYPE_RESET;
        model_threshold = THRESHOLD_RESET;
        ts_model        = '0;
        last_ts         = '0;
        check_on        = 1'b0;
        data_on         = 1'b0;
        hg_on           = 1'b0;
        exp_valid       = 1'b0;
        exp_frame       = '0;
        exp_hg          = '0;
        repeat (8) @(negedge ACLK);
        ARESET = 1'b0;

        axil_write(REG_THRESHOLD, 32'd24000);
        axil_read(REG_THRESHOLD, 32'd24000, "threshold readback");
        axil_write(REG_TRIG_TYPE, 32'(EXTERNAL_TRG));
        axil_read(REG_TRIG_TYPE, 32'(EXTERNAL_TRG), "trigger type readback");
        axil_write(REG_TRIG_TYPE, 32'(HARDWARE_TRG));
        axil_read(REG_TRIG_TYPE, 32'(HARDWARE_TRG), "trigger type readback");
        axil_write(REG_CTRL, 32'd1);
        axil_read(REG_CTRL, 32'd1, "stop readback");
        axil_write(REG_CTRL, 32'd0);
        axil_read(REG_CTRL, 32'd0, "stop readback");
        axil_read(4'h6, 32'd0, "unmapped readback");

        // hardware trigger with stop and a threshold change while streaming
        stream_on = 1'b1;
        run_cycles(200);
        axil_write(REG_CTRL, 32'd1);
        run_cycles(40);
        axil_write(REG_CTRL, 32'd0);
        run_cycles(40);
        axil_write(REG_THRESHOLD, 32'h0000_E000);
        run_cycles(60);
        axil_write(REG_THRESHOLD, 32'd24000);
        run_cycles(20);

        // external trigger pulses while samples keep arriving
        axil_write(REG_TRIG_TYPE, 32'(EXTERNAL_TRG));
        run_cycles(10);
        repeat (12) begin
            ext_request = 1'b1;
            run_cycles(7);
        end
        axil_write(REG_TRIG_TYPE, 32'(HARDWARE_TRG));
        run_cycles(50);

        stream_on = 1'b0;
        run_cycles(8);
        axil_read(REG_FRAME_COUNT, 32'(seen_frames), "frame count");
        finish_run();
    end

endmodule

/* compile.f */
source/daq_format_pkg.sv
source/trigger_pkg.sv
source/axil_trigger_regs.sv
source/threshold_trigger.sv
source/trigger_selector.sv
source/trigger_frontend_top.sv
verif/tb_trigger_frontend.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_trigger_frontend -f compile.f -o tb_trigger_frontend
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_trigger_frontend > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -F -q -- '>>> FAIL' "$LOG"; then
    echo "testbench reported a failure"
    exit 1
fi

echo "simulation finished without failures"
exit 0
